/* sources.f */
+incdir+verif
rtl/wh_mem_pkg.sv
rtl/wh_mem_ctrl.sv
rtl/wh_mem_bank.sv
rtl/wh_mem_cfg.sv
rtl/wh_mem_top.sv
verif/wh_mem_tb.sv

/* verif/wh_mem_tb_tasks.svh */
`ifndef WH_MEM_TB_TASKS_SVH
`define WH_MEM_TB_TASKS_SVH

// {cache_sel, block_idx, beat} worked out arithmetically
function automatic int hash_index(hash_mode_e m, logic [7:0] src, logic [1:0] cid,
                                  logic [31:0] addr, int beat);
  int blocks;
  int cache_sel;
  int block_idx;
  blocks    = mem_els_lp / (num_caches_lp * block_len_lp);
  block_idx = (addr / (block_len_lp * 4)) % blocks;
  if (m == spread) begin
    cache_sel = (src / ruche_factor_lp) % num_caches_lp;
  end else begin
    cache_sel = ((cid / ruche_factor_lp) % 2) * (num_caches_lp / 2)
              + src % (num_caches_lp / 2);
  end
  return (cache_sel * blocks + block_idx) * block_len_lp + beat;
endfunction

task automatic evict_block(logic [7:0] src, logic [1:0] cid, logic [31:0] addr,
                           logic [3:0] len);
  wh_flit_u    hdr;
  logic [31:0] w;
  hdr                    = '0;
  hdr.hdr.write_not_read = 1'b1;
  hdr.hdr.src_cord       = src;
  hdr.hdr.cid            = cid;
  hdr.hdr.len            = len;
  send_flit(hdr.raw);
  send_flit(addr);
  for (int b = 0; b < block_len_lp; b++) begin
    w = rand_word();
    model_mem[hash_index(cur_mode, src, cid, addr, b)] = w;
    send_flit(w);
  end
  release_link();
  exp_writes++;
endtask

task automatic fill_block(logic [7:0] src, logic [1:0] cid, logic [31:0] addr,
                          logic random_ready);
  wh_flit_u hdr;
  wh_flit_u exp_hdr;
  hdr                   = '0;
  hdr.hdr.src_cord      = src;
  hdr.hdr.cid           = cid;
  hdr.hdr.len           = 4'(block_len_lp);
  exp_hdr               = '0;
  exp_hdr.hdr.dest_cord = src; // reply goes back to the requester
  exp_hdr.hdr.cid       = cid;
  exp_hdr.hdr.len       = 4'(block_len_lp);
  send_flit(hdr.raw);
  send_flit(addr);
  release_link();
  recv_flit("wh_link_o.data header", exp_hdr.raw, random_ready);
  for (int b = 0; b < block_len_lp; b++) begin
    recv_flit("wh_link_o.data", model_mem[hash_index(cur_mode, src, cid, addr, b)],
              random_ready);
  end
  release_link();
  exp_reads++;
endtask

task automatic reset_state_check();
  int n;
  n = 0;
  #1;
  check_value("wh_link_o.v", rsp_link.v, 1'b0);
  check_value("stat_writes_o", stat_writes, 0);
  check_value("stat_reads_o", stat_reads, 0);
  check_value("len_err_o", len_err, 1'b0);
  check_value("mode_o", mode, concentrated);
  while (!rsp_link.ready_and_rev && n < 2) begin
    @(negedge clk_i);
    #1;
    n++;
  end
  if (!rsp_link.ready_and_rev) begin
    report_failure("ready_and_rev did not rise within two cycles of reset");
  end
endtask

// four requesters on one block address land in four concentrated slots
task automatic concentrated_traffic();
  for (int i = 0; i < 4; i++) begin
    evict_block(8'(i % 2), 2'(i < 2 ? 0 : i), 32'h40, 4'(block_len_lp));
  end
  for (int i = 0; i < 4; i++) begin
    fill_block(8'(i % 2), 2'(i < 2 ? 0 : i), 32'h40, 1'b0);
  end
endtask

task automatic mode_collision();
  // cords 01 and 03 share a slot when concentrated only
  set_mode(spread);
  evict_block(8'h01, 2'd0, 32'h300, 4'(block_len_lp));
  evict_block(8'h03, 2'd0, 32'h300, 4'(block_len_lp));
  fill_block(8'h01, 2'd0, 32'h300, 1'b0);
  fill_block(8'h03, 2'd0, 32'h300, 1'b0);
  set_mode(concentrated);
  evict_block(8'h01, 2'd0, 32'h300, 4'(block_len_lp));
  evict_block(8'h03, 2'd0, 32'h300, 4'(block_len_lp));
  fill_block(8'h01, 2'd0, 32'h300, 1'b0); // second write wins
  fill_block(8'h03, 2'd0, 32'h300, 1'b0);
endtask

task automatic random_backpressure();
  evict_block(8'h02, 2'd1, 32'h150, 4'(block_len_lp));
  repeat (3) begin
    fill_block(8'h02, 2'd1, 32'h150, 1'b1);
  end
endtask

task automatic status_counters();
  check_value("stat_writes_o", stat_writes, exp_writes);
  check_value("stat_reads_o", stat_reads, exp_reads);
  check_value("len_err_o", len_err, 1'b0);
  evict_block(8'h05, 2'd2, 32'he0, 4'(block_len_lp - 2)); // short len field
  fill_block(8'h05, 2'd2, 32'he0, 1'b0);
  #1;
  check_value("len_err_o", len_err, 1'b1);
  check_value("stat_writes_o", stat_writes, exp_writes);
  check_value("stat_reads_o", stat_reads, exp_reads);
  @(negedge clk_i);
  cfg_clr = 1'b1;
  @(negedge clk_i);
  cfg_clr = 1'b0;
  #1;
  check_value("stat_writes_o", stat_writes, 0);
  check_value("stat_reads_o", stat_reads, 0);
  check_value("len_err_o", len_err, 1'b0);
endtask

`endif

/* verif/wh_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module wh_mem_tb
  import wh_mem_pkg::*;
();

  localparam int block_len_lp    = 4;
  localparam int mem_els_lp      = 512;
  localparam int num_caches_lp   = 4;
  localparam int ruche_factor_lp = 2;
  localparam int num_tests_lp    = 5;

  logic        clk_i;
  logic        reset_i;
  wh_link_s    req_link; // into the endpoint
  wh_link_s    rsp_link;
  logic        cfg_we;
  hash_mode_e  cfg_mode;
  logic        cfg_clr;
  hash_mode_e  mode;
  logic [15:0] stat_writes;
  logic [15:0] stat_reads;
  logic        len_err;

  logic [31:0] lfsr;
  logic [31:0] model_mem [mem_els_lp];
  hash_mode_e  cur_mode;
  int          exp_writes;
  int          exp_reads;
  int          checks;
  int          errors;

  wh_mem_top #(
    .block_len_p   (block_len_lp),
    .mem_els_p     (mem_els_lp),
    .num_caches_p  (num_caches_lp),
    .ruche_factor_p(ruche_factor_lp)
  ) dut_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wh_link_i    (req_link),
    .wh_link_o    (rsp_link),
    .cfg_we_i     (cfg_we),
    .cfg_mode_i   (cfg_mode),
    .cfg_clr_i    (cfg_clr),
    .mode_o       (mode),
    .stat_writes_o(stat_writes),
    .stat_reads_o (stat_reads),
    .len_err_o    (len_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'ha3000000; // galois taps
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  task automatic send_flit(logic [31:0] word);
    int waits;
    waits = 0;
    @(negedge clk_i);
    req_link.v        = 1'b1;
    req_link.data.raw = word;
    #1;
    while (!rsp_link.ready_and_rev && waits < 20) begin
      @(negedge clk_i);
      #1;
      waits++;
    end
    if (!rsp_link.ready_and_rev) begin
      report_failure("inbound flit was not accepted within 20 cycles");
    end
    @(posedge clk_i);
  endtask

  // compare on acceptance, hold check while stalled
  task automatic recv_flit(string name, logic [31:0] exp, logic random_ready);
    logic        got;
    logic        held_valid;
    logic [31:0] held;
    int          waits;
    got        = 1'b0;
    held_valid = 1'b0;
    held       = '0;
    waits      = 0;
    while (!got && waits < 20) begin
      @(negedge clk_i);
      req_link.ready_and_rev = random_ready ? lfsr_bit() : 1'b1;
      #1;
      if (held_valid && (!rsp_link.v || rsp_link.data.raw !== held)) begin
        report_failure("stalled outbound flit dropped v or changed its data");
      end
      if (rsp_link.v && req_link.ready_and_rev) begin
        check_value(name, rsp_link.data.raw, exp);
        got = 1'b1;
      end else if (rsp_link.v) begin
        held       = rsp_link.data.raw;
        held_valid = 1'b1;
      end
      waits++;
      @(posedge clk_i);
    end
    if (!got) begin
      report_failure("no outbound flit was accepted within 20 cycles");
    end
  endtask

  task automatic release_link();
    @(negedge clk_i);
    req_link.v             = 1'b0;
    req_link.ready_and_rev = 1'b0;
  endtask

  task automatic set_mode(hash_mode_e m);
    @(negedge clk_i);
    cfg_we   = 1'b1;
    cfg_mode = m;
    @(negedge clk_i);
    cfg_we = 1'b0;
    #1;
    check_value("mode_o", mode, m);
    cur_mode = m;
  endtask

  initial begin
    lfsr       = 32'h8c640170;
    cur_mode   = concentrated;
    exp_writes = 0;
    exp_reads  = 0;
    checks     = 0;
    errors     = 0;
    reset_i    = 1'b1;
    req_link   = '0;
    cfg_we     = 1'b0;
    cfg_mode   = concentrated;
    cfg_clr    = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    reset_state_check();
    concentrated_traffic();
    mode_collision();
    random_backpressure();
    status_counters();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (num_tests_lp * 200) @(posedge clk_i);
    $display("timeout: run did not finish in %0d cycles", num_tests_lp * 200);
    $display("=== FAIL ===");
    $finish;
  end

  `include "wh_mem_tb_tasks.svh"

endmodule

`default_nettype wire

/* rtl/wh_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module wh_mem_top
  import wh_mem_pkg::*;
#(
  parameter int block_len_p    = 4,
  parameter int mem_els_p      = 512,
  parameter int num_caches_p   = 4,
  parameter int ruche_factor_p = 2
) (
  input  logic        clk_i,
  input  logic        reset_i,

  input  wh_link_s    wh_link_i,
  output wh_link_s    wh_link_o,

  input  logic        cfg_we_i,
  input  hash_mode_e  cfg_mode_i,
  input  logic        cfg_clr_i,

  output hash_mode_e  mode_o,
  output logic [15:0] stat_writes_o,
  output logic [15:0] stat_reads_o,
  output logic        len_err_o
);

  localparam int beat_width_lp = $clog2(block_len_p);

  logic                     mem_we;
  logic [beat_width_lp-1:0] beat;
  logic [cord_width_c-1:0]  src_cord;
  logic [cid_width_c-1:0]   cid;
  logic [flit_width_c-1:0]  addr;
  logic [flit_width_c-1:0]  rd_data;

  logic wr_done;
  logic rd_done;
  logic len_err;
  logic idle;

  wh_mem_ctrl #(
    .block_len_p(block_len_p)
  ) ctrl_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .link_i    (wh_link_i),
    .link_o    (wh_link_o),
    .rd_data_i (rd_data),
    .mem_we_o  (mem_we),
    .beat_o    (beat),
    .src_cord_o(src_cord),
    .cid_o     (cid),
    .addr_o    (addr),
    .wr_done_o (wr_done),
    .rd_done_o (rd_done),
    .len_err_o (len_err),
    .idle_o    (idle)
  );

  wh_mem_bank #(
    .block_len_p   (block_len_p),
    .mem_els_p     (mem_els_p),
    .num_caches_p  (num_caches_p),
    .ruche_factor_p(ruche_factor_p)
  ) bank_i (
    .clk_i     (clk_i),
    .we_i      (mem_we),
    .beat_i    (beat),
    .src_cord_i(src_cord),
    .cid_i     (cid),
    .addr_i    (addr),
    .mode_i    (mode_o),
    .wr_data_i (wh_link_i.data.raw), // evict data straight off the link
    .rd_data_o (rd_data)
  );

  wh_mem_cfg #(
    .block_len_p(block_len_p)
  ) cfg_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_mode_i   (cfg_mode_i),
    .cfg_clr_i    (cfg_clr_i),
    .idle_i       (idle),
    .wr_done_i    (wr_done),
    .rd_done_i    (rd_done),
    .len_err_i    (len_err),
    .mode_o       (mode_o),
    .stat_writes_o(stat_writes_o),
    .stat_reads_o (stat_reads_o),
    .len_err_o    (len_err_o)
  );

endmodule

`default_nettype wire

/* rtl/wh_mem_cfg.sv */
`timescale 1ns/100ps
`default_nettype none

module wh_mem_cfg
  import wh_mem_pkg::*;
#(
  parameter int block_len_p = 4
) (
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        cfg_we_i,
  input  hash_mode_e  cfg_mode_i,
  input  logic        cfg_clr_i,

  input  logic        idle_i,
  input  logic        wr_done_i,
  input  logic        rd_done_i,
  input  logic        len_err_i,

  output hash_mode_e  mode_o,
  output logic [15:0] stat_writes_o,
  output logic [15:0] stat_reads_o,
  output logic        len_err_o
);

  hash_mode_e pending_r;
  hash_mode_e pending_n;
  logic       done;

  assign pending_n = cfg_we_i ? cfg_mode_i : pending_r;
  assign done      = wr_done_i | rd_done_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= concentrated;
      mode_o    <= concentrated;
    end else begin
      pending_r <= pending_n;
      if (idle_i) begin
        mode_o <= pending_n; // never switch inside a block
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || cfg_clr_i) begin
      stat_writes_o <= '0;
      stat_reads_o  <= '0;
      len_err_o     <= 1'b0;
    end else begin
      if (wr_done_i && (stat_writes_o != '1)) begin
        stat_writes_o <= stat_writes_o + 1'b1;
      end
      if (rd_done_i && (stat_reads_o != '1)) begin
        stat_reads_o <= stat_reads_o + 1'b1;
      end
      if (len_err_i) begin
        len_err_o <= 1'b1; // sticky
      end
    end
  end

  a_mode_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !idle_i |=> $stable(mode_o));

  // header, address and a full block lie between two completions
  a_done_gap: assert property (@(posedge clk_i) disable iff (reset_i)
    done |=> !done [*(block_len_p+1)]);

endmodule

`default_nettype wire

/* rtl/wh_mem_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module wh_mem_bank
  import wh_mem_pkg::*;
#(
  parameter int block_len_p    = 4,
  parameter int mem_els_p      = 512,
  parameter int num_caches_p   = 4,
  parameter int ruche_factor_p = 2,
  localparam int beat_width_lp = $clog2(block_len_p)
) (
  input  logic                     clk_i,
  input  logic                     we_i,
  input  logic [beat_width_lp-1:0] beat_i,
  input  logic [cord_width_c-1:0]  src_cord_i,
  input  logic [cid_width_c-1:0]   cid_i,
  input  logic [flit_width_c-1:0]  addr_i,
  input  hash_mode_e               mode_i,
  input  logic [flit_width_c-1:0]  wr_data_i,
  output logic [flit_width_c-1:0]  rd_data_o
);

  localparam int idx_width_lp = $clog2(mem_els_p);
  localparam int lg_caches_lp = $clog2(num_caches_p);
  localparam int lg_ruche_lp  = $clog2(ruche_factor_p);
  localparam int block_off_lp = $clog2(block_len_p * 4); // byte offset within a block
  localparam int blk_width_lp = idx_width_lp - lg_caches_lp - beat_width_lp;

  logic [flit_width_c-1:0] mem_r [mem_els_p];

  logic [cid_width_c-1:0]  cid_half;
  logic [lg_caches_lp-1:0] cache_sel;
  logic [blk_width_lp-1:0] block_idx;
  logic [idx_width_lp-1:0] mem_idx;

  // north or south cache row
  assign cid_half = cid_i / cid_width_c'(ruche_factor_p);

  always_comb begin
    if (mode_i == spread) begin
      cache_sel = src_cord_i[lg_ruche_lp +: lg_caches_lp];
    end else begin
      cache_sel = {cid_half[0], src_cord_i[0 +: lg_caches_lp-1]};
    end
  end

  assign block_idx = addr_i[block_off_lp +: blk_width_lp];
  assign mem_idx   = {cache_sel, block_idx, beat_i};

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_r[mem_idx] <= wr_data_i;
    end
  end

  assign rd_data_o = mem_r[mem_idx];

  // only matters when mem_els_p is not a power of two
  a_idx_range: assert property (@(posedge clk_i)
    we_i |-> mem_idx < mem_els_p);

endmodule

`default_nettype wire

/* rtl/wh_mem_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module wh_mem_ctrl
  import wh_mem_pkg::*;
#(
  parameter int block_len_p = 4,
  localparam int beat_width_lp = $clog2(block_len_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  wh_link_s                 link_i,
  output wh_link_s                 link_o,

  input  logic [flit_width_c-1:0]  rd_data_i,
  output logic                     mem_we_o,
  output logic [beat_width_lp-1:0] beat_o,
  output logic [cord_width_c-1:0]  src_cord_o,
  output logic [cid_width_c-1:0]   cid_o,
  output logic [flit_width_c-1:0]  addr_o,

  output logic                     wr_done_o,
  output logic                     rd_done_o,
  output logic                     len_err_o,
  output logic                     idle_o
);

  typedef enum logic [2:0] {
    s_reset,
    s_ready,
    s_addr,
    s_evict_data,
    s_fill_header,
    s_fill_data
  } state_e;

  state_e state_r;
  state_e state_n;

  logic                     write_not_read_r;
  logic [cord_width_c-1:0]  src_cord_r;
  logic [cid_width_c-1:0]   cid_r;
  logic [flit_width_c-1:0]  addr_r;
  logic [beat_width_lp-1:0] beat_r;

  logic     in_hs;
  logic     out_hs;
  logic     last_beat;
  logic     beat_up;
  wh_flit_u ret_hdr;

  assign in_hs     = link_i.v & link_o.ready_and_rev;
  assign out_hs    = link_o.v & link_i.ready_and_rev;
  assign last_beat = (beat_r == beat_width_lp'(block_len_p - 1));

  // reply header goes back to the requester
  always_comb begin
    ret_hdr               = '0;
    ret_hdr.hdr.dest_cord = src_cord_r;
    ret_hdr.hdr.cid       = cid_r;
    ret_hdr.hdr.len       = len_width_c'(block_len_p);
  end

  always_comb begin
    link_o  = '0;
    state_n = state_r;

    case (state_r)
      s_reset: begin
        state_n = s_ready;
      end

      s_ready: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          state_n = s_addr;
        end
      end

      s_addr: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          state_n = write_not_read_r ? s_evict_data : s_fill_header;
        end
      end

      s_evict_data: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v && last_beat) begin
          state_n = s_ready;
        end
      end

      s_fill_header: begin
        link_o.v    = 1'b1;
        link_o.data = ret_hdr;
        if (link_i.ready_and_rev) begin
          state_n = s_fill_data;
        end
      end

      s_fill_data: begin
        link_o.v        = 1'b1;
        link_o.data.raw = rd_data_i; // bank read is combinational
        if (link_i.ready_and_rev && last_beat) begin
          state_n = s_ready;
        end
      end

      default: begin
        state_n = s_ready;
      end
    endcase
  end

  assign mem_we_o = (state_r == s_evict_data) & in_hs;
  assign beat_up  = mem_we_o | ((state_r == s_fill_data) & out_hs);

  assign wr_done_o = mem_we_o & last_beat;
  assign rd_done_o = (state_r == s_fill_data) & out_hs & last_beat;
  assign len_err_o = (state_r == s_ready) & in_hs
                   & (link_i.data.hdr.len != len_width_c'(block_len_p));
  assign idle_o    = (state_r == s_ready);

  assign beat_o     = beat_r;
  assign src_cord_o = src_cord_r;
  assign cid_o      = cid_r;
  assign addr_o     = addr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_reset;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      if (beat_up) begin
        beat_r <= last_beat ? '0 : beat_r + 1'b1;
      end
    end
  end

  // request fields, held for the whole block
  always_ff @(posedge clk_i) begin
    if ((state_r == s_ready) && in_hs) begin
      write_not_read_r <= link_i.data.hdr.write_not_read;
      src_cord_r       <= link_i.data.hdr.src_cord;
      cid_r            <= link_i.data.hdr.cid;
    end
    if ((state_r == s_addr) && in_hs) begin
      addr_r <= link_i.data.raw;
    end
  end

  // a stalled flit must not move, including the bank read behind it
  a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    link_o.v && !link_i.ready_and_rev |=> link_o.v && $stable(link_o.data));

  // evict beats only follow a write header
  a_we_state: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_we_o |-> write_not_read_r);

endmodule

`default_nettype wire

/* rtl/wh_mem_pkg.sv */
`default_nettype none

package wh_mem_pkg;

  localparam int flit_width_c = 32;
  localparam int cord_width_c = 8;
  localparam int cid_width_c  = 2;
  localparam int len_width_c  = 4;

  // bits left over above the header fields
  localparam int unused_width_c =
    flit_width_c - 2*cord_width_c - cid_width_c - len_width_c - 1;

  typedef struct packed {
    logic [unused_width_c-1:0] unused;
    logic                      write_not_read;
    logic [cord_width_c-1:0]   src_cord;
    logic [cid_width_c-1:0]    cid;
    logic [len_width_c-1:0]    len;
    logic [cord_width_c-1:0]   dest_cord;
  } wh_header_s;

  // same link word, seen as header or as address/data
  typedef union packed {
    wh_header_s              hdr;
    logic [flit_width_c-1:0] raw;
  } wh_flit_u;

  typedef struct packed {
    logic     v;
    logic     ready_and_rev;
    wh_flit_u data;
  } wh_link_s;

  typedef enum logic {
    concentrated = 1'b0, // two cache rows per link
    spread       = 1'b1  // one endpoint per link
  } hash_mode_e;

endpackage

`default_nettype wire
